// File: nnPkg.sv
package nnPkg;

	// **************************************************
	// Layer geometry
	// **************************************************

	// Inputs per neuron
	localparam int FAN_IN = 15;

	// 15 products of 16 bits plus a 16-bit bias fit in 23 bits
	localparam int ACC_WIDTH = 23;

	// Activation ceiling after ReLU
	localparam int ACT_MAX = 127;

	// **************************************************
	// Datapath types
	// **************************************************

	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	// One layer input, element 0 in the low bits
	typedef activation_t [FAN_IN-1:0] inVector_t;

	// Bias sits above the weights
	typedef struct packed {
		bias_t bias;
		weight_t [FAN_IN-1:0] weights;
	} weightRow_t;

	// Controller states
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN,
		OUTPUT
	} layerState_t;

endpackage

// File: neuronDot.sv
`timescale 1ns/1ps

module neuronDot #(
	parameter int INDEX_WIDTH = 4
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [INDEX_WIDTH-1:0] inIndex,
	input nnPkg::inVector_t vec,
	input nnPkg::weightRow_t row,
	output logic outValid,
	output logic [INDEX_WIDTH-1:0] outIndex,
	output nnPkg::activation_t result
);
	import nnPkg::*;

	logic valid1;
	logic valid2;
	logic [INDEX_WIDTH-1:0] index1;
	logic [INDEX_WIDTH-1:0] index2;
	inVector_t vecReg;
	weightRow_t rowReg;
	acc_t sumNext;
	acc_t sumReg;
	acc_t rounded;
	acc_t shifted;
	activation_t actNext;

	// Dot product plus bias
	always_comb
	begin
		activation_t a;
		weight_t w;
		sumNext = acc_t'(rowReg.bias);
		for (int i = 0; i < FAN_IN; i++)
		begin
			a = vecReg[i];
			w = rowReg.weights[i];
			sumNext = sumNext + acc_t'(a) * acc_t'(w);
		end
	end

	// ReLU, round half up, saturate
	always_comb
	begin
		rounded = sumReg + acc_t'(32);
		shifted = rounded >>> 6;
		if (sumReg < 0)
			actNext = '0;
		else if (shifted > acc_t'(ACT_MAX))
			actNext = activation_t'(ACT_MAX);
		else
			actNext = activation_t'(shifted);
	end

	// Valid travels beside the data
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			valid1 <= inValid;
			valid2 <= valid1;
			outValid <= valid2;
		end
	end

	always_ff @(posedge clk)
	begin
		vecReg <= vec;
		rowReg <= row;
		index1 <= inIndex;
		sumReg <= sumNext;
		index2 <= index1;
		result <= actNext;
		outIndex <= index2;
	end

endmodule

// File: weightStore.sv
`timescale 1ns/1ps

module weightStore #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic loadEn,
	input logic [$clog2(NUM_NEURONS)-1:0] loadAddr,
	input nnPkg::weightRow_t loadRow,
	input logic readEn,
	input logic [$clog2(NUM_NEURONS)-1:0] readAddr,
	output logic rowValid,
	output logic [$clog2(NUM_NEURONS)-1:0] rowIndex,
	output nnPkg::weightRow_t row
);
	import nnPkg::*;

	localparam int INDEX_WIDTH = $clog2(NUM_NEURONS);

	// One row per neuron
	weightRow_t mem [NUM_NEURONS];

	logic [INDEX_WIDTH-1:0] lastAddr;

	assign lastAddr = INDEX_WIDTH'(NUM_NEURONS - 1);

	// Write port, addresses past the last neuron are dropped
	always_ff @(posedge clk)
	begin
		if (loadEn && loadAddr <= lastAddr)
			mem[loadAddr] <= loadRow;
	end

	// Registered read, index and flag follow the row
	always_ff @(posedge clk)
	begin
		rowValid <= readEn;
		rowIndex <= readAddr;
		if (readEn)
			row <= mem[readAddr];
	end

endmodule

// File: neuronCounter.sv
`timescale 1ns/1ps

module neuronCounter #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic reset,
	input logic start,
	output logic issue,
	output logic [$clog2(NUM_NEURONS)-1:0] index,
	output logic last
);

	localparam int INDEX_WIDTH = $clog2(NUM_NEURONS);

	logic busy;

	assign issue = busy;
	assign last = busy && (index == INDEX_WIDTH'(NUM_NEURONS - 1));

	// One index per cycle, stops after the final one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			index <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			index <= '0;
		end
		else if (busy)
		begin
			if (last)
				busy <= 1'b0;
			else
				index <= index + 1'b1;
		end
	end

endmodule

// File: layerControl.sv
`timescale 1ns/1ps

module layerControl #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnPkg::inVector_t inData,
	output nnPkg::inVector_t vec,
	output logic start,
	input logic last,
	input logic full,
	output logic outValid,
	input logic outReady
);
	import nnPkg::*;

	layerState_t state;
	layerState_t stateNext;

	// Index width and buffer layout assume this range
	if (NUM_NEURONS < 2 || NUM_NEURONS > 64)
	begin : badSize
		$error("layerControl: NUM_NEURONS must be 2 to 64");
	end

	// Nothing is taken in while reset is held
	assign inReady = (state == IDLE) && !reset;
	assign outValid = (state == OUTPUT);

	// Counter starts on the accepting edge so RUN issues at once
	assign start = inValid && inReady;

	// **************************************************
	// Next state
	// **************************************************
	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
				if (start)
					stateNext = RUN;
			RUN:
				if (last)
					stateNext = DRAIN;
			DRAIN:
				if (full)
					stateNext = OUTPUT;
			OUTPUT:
				if (outReady)
					stateNext = IDLE;
			default:
				stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= stateNext;
	end

	// Held for the whole pass
	always_ff @(posedge clk)
	begin
		if (start)
			vec <= inData;
	end

endmodule

// File: resultBuffer.sv
`timescale 1ns/1ps

module resultBuffer #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic reset,
	input logic resValid,
	input logic [$clog2(NUM_NEURONS)-1:0] resIndex,
	input nnPkg::activation_t result,
	output logic full,
	output nnPkg::activation_t [NUM_NEURONS-1:0] outData
);

	localparam int INDEX_WIDTH = $clog2(NUM_NEURONS);

	logic [INDEX_WIDTH-1:0] lastIndex;

	assign lastIndex = INDEX_WIDTH'(NUM_NEURONS - 1);

	// High while the last slot is being written
	assign full = resValid && (resIndex == lastIndex);

	// **************************************************
	// Result slots
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (reset)
			outData <= '0;
		else if (resValid && resIndex <= lastIndex)
			outData[resIndex] <= result;
	end

endmodule

// File: layerEngine.sv
`timescale 1ns/1ps

module layerEngine #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnPkg::inVector_t inData,
	output logic outValid,
	input logic outReady,
	output nnPkg::activation_t [NUM_NEURONS-1:0] outData,
	input logic loadEn,
	input logic [$clog2(NUM_NEURONS)-1:0] loadAddr,
	input nnPkg::weightRow_t loadRow
);
	import nnPkg::*;

	localparam int INDEX_WIDTH = $clog2(NUM_NEURONS);

	inVector_t vec;
	logic start;
	logic issue;
	logic last;
	logic full;
	logic [INDEX_WIDTH-1:0] issueIndex;

	logic rowValid;
	logic [INDEX_WIDTH-1:0] rowIndex;
	weightRow_t row;

	logic resValid;
	logic [INDEX_WIDTH-1:0] resIndex;
	activation_t result;

	layerControl #(
		.NUM_NEURONS(NUM_NEURONS)
	) control (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.vec(vec),
		.start(start),
		.last(last),
		.full(full),
		.outValid(outValid),
		.outReady(outReady)
	);

	neuronCounter #(
		.NUM_NEURONS(NUM_NEURONS)
	) counter (
		.clk(clk),
		.reset(reset),
		.start(start),
		.issue(issue),
		.index(issueIndex),
		.last(last)
	);

	weightStore #(
		.NUM_NEURONS(NUM_NEURONS)
	) weights (
		.clk(clk),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadRow(loadRow),
		.readEn(issue),
		.readAddr(issueIndex),
		.rowValid(rowValid),
		.rowIndex(rowIndex),
		.row(row)
	);

	// Shared by every neuron of the layer
	neuronDot #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) neuron (
		.clk(clk),
		.reset(reset),
		.inValid(rowValid),
		.inIndex(rowIndex),
		.vec(vec),
		.row(row),
		.outValid(resValid),
		.outIndex(resIndex),
		.result(result)
	);

	resultBuffer #(
		.NUM_NEURONS(NUM_NEURONS)
	) buffer (
		.clk(clk),
		.reset(reset),
		.resValid(resValid),
		.resIndex(resIndex),
		.result(result),
		.full(full),
		.outData(outData)
	);

endmodule

// File: layerEngine_asserts.sv
`timescale 1ns/1ps

module layerEngine_asserts #(
	parameter int NUM_NEURONS = 16
) (
	input logic clk,
	input logic reset,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input nnPkg::activation_t [NUM_NEURONS-1:0] outData,
	input logic loadEn
);
	import nnPkg::*;

	logic anyNegative;

	// A value above 127 would show up as a negative element
	always_comb
	begin
		anyNegative = 1'b0;
		for (int i = 0; i < NUM_NEURONS; i++)
			anyNegative = anyNegative | outData[i][7];
	end

	readyOrValid: assert property (@(posedge clk) disable iff (reset)
		!(inReady && outValid))
		else $error("inReady and outValid high together");

	outputHeld: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("Output vector changed or dropped before outReady");

	// inReady is high only while idle
	loadWhileIdle: assert property (@(posedge clk) disable iff (reset)
		loadEn |-> inReady)
		else $error("Weight load outside the idle state");

	outputRange: assert property (@(posedge clk) disable iff (reset)
		outValid |-> !anyNegative)
		else $error("Output element outside 0 to 127");

endmodule

bind layerEngine layerEngine_asserts #(
	.NUM_NEURONS(NUM_NEURONS)
) checks (
	.clk(clk),
	.reset(reset),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.outData(outData),
	.loadEn(loadEn)
);

// File: tb_layerEngine.sv
`timescale 1ns/1ps

module tb_layerEngine;
	import nnPkg::*;

	localparam int NUM_NEURONS = 16;
	localparam int INDEX_WIDTH = $clog2(NUM_NEURONS);
	localparam int WAIT_LIMIT = 200;

	typedef activation_t [NUM_NEURONS-1:0] outVector_t;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic inReady;
	inVector_t inData;
	logic outValid;
	logic outReady;
	outVector_t outData;
	logic loadEn;
	logic [INDEX_WIDTH-1:0] loadAddr;
	weightRow_t loadRow;

	// One entry per record of the data file
	bit isVector[$];
	int rowAddr[$];
	weightRow_t rowData[$];
	inVector_t vecData[$];
	outVector_t expData[$];
	string testName[$];

	integer seed;
	int vectorCount;

	layerEngine #(
		.NUM_NEURONS(NUM_NEURONS)
	) UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadRow(loadRow)
	);

	always #20 clk = ~clk;

	// **************************************************
	// Reporting
	// **************************************************

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic checkValue(input string name, input string what,
		input int expected, input int actual);
		if (expected != actual)
			abortRun($sformatf("Mismatch in test %s, %s: expected %0d, actual %0d",
				name, what, expected, actual));
	endtask

	// **************************************************
	// Data file
	// **************************************************

	task automatic readNumber(input integer fd, output integer value);
		integer code;
		code = $fscanf(fd, "%d", value);
		if (code != 1)
			abortRun("Test data file ends inside a record or holds a bad number");
	endtask

	task automatic storeRecord(input bit vector, input int addr, input weightRow_t row,
		input inVector_t vec, input outVector_t expected, input string name);
		isVector.push_back(vector);
		rowAddr.push_back(addr);
		rowData.push_back(row);
		vecData.push_back(vec);
		expData.push_back(expected);
		testName.push_back(name);
	endtask

	task automatic readTestData();
		integer fd;
		integer code;
		integer num;
		integer addr;
		logic [8*16-1:0] tag;
		logic [8*32-1:0] name;
		logic [8*128-1:0] line;
		weightRow_t row;
		inVector_t vec;
		outVector_t expected;
		fd = $fopen("layerEngine_testdata.txt", "r");
		if (fd == 0)
			abortRun("Cannot open layerEngine_testdata.txt");
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag == "#")
				code = $fgets(line, fd);
			else if (tag == "W")
			begin
				readNumber(fd, addr);
				for (int i = 0; i < FAN_IN; i++)
				begin
					readNumber(fd, num);
					row.weights[i] = weight_t'(num);
				end
				readNumber(fd, num);
				row.bias = bias_t'(num);
				storeRecord(1'b0, addr, row, '0, '0, "");
			end
			else if (tag == "V")
			begin
				code = $fscanf(fd, "%s", name);
				if (code != 1)
					abortRun("Test data file ends before the name of a vector");
				for (int i = 0; i < FAN_IN; i++)
				begin
					readNumber(fd, num);
					vec[i] = activation_t'(num);
				end
				for (int n = 0; n < NUM_NEURONS; n++)
				begin
					readNumber(fd, num);
					expected[n] = activation_t'(num);
				end
				storeRecord(1'b1, 0, '0, vec, expected, $sformatf("%0s", name));
				vectorCount++;
			end
			else
				abortRun($sformatf("Unknown record type %0s in test data", tag));
		end
		$fclose(fd);
	endtask

	// **************************************************
	// Stimulus
	// **************************************************

	task automatic loadWeights(input int op);
		int count;
		count = 0;
		while (!inReady)
		begin
			@(posedge clk);
			#2;
			count++;
			if (count > WAIT_LIMIT)
				abortRun("Engine never became idle for a weight load");
		end
		loadEn = 1'b1;
		loadAddr = INDEX_WIDTH'(rowAddr[op]);
		loadRow = rowData[op];
		@(posedge clk);
		#2;
		loadEn = 1'b0;
	endtask

	task automatic runVector(input int op);
		int count;
		int latency;
		logic [31:0] randomBits;
		bit done;
		inData = vecData[op];
		inValid = 1'b1;
		count = 0;
		while (!inReady)
		begin
			@(posedge clk);
			#2;
			count++;
			if (count > WAIT_LIMIT)
				abortRun($sformatf("Input vector %s was never accepted", testName[op]));
		end
		@(posedge clk);
		#2;
		// A following vector already waits at the input
		if (op + 1 < isVector.size() && isVector[op + 1])
			inData = vecData[op + 1];
		else
			inValid = 1'b0;
		latency = 0;
		while (!outValid)
		begin
			@(posedge clk);
			#2;
			latency++;
			if (latency > WAIT_LIMIT)
				abortRun($sformatf("No output vector for test %s", testName[op]));
		end
		checkValue(testName[op], "latency", NUM_NEURONS + 4, latency);
		done = 1'b0;
		count = 0;
		while (!done)
		begin
			checkValue(testName[op], "inReady during output", 0, int'(inReady));
			checkValue(testName[op], "outValid held", 1, int'(outValid));
			for (int n = 0; n < NUM_NEURONS; n++)
				checkValue(testName[op], $sformatf("neuron %0d", n),
					int'(expData[op][n]), int'(outData[n]));
			randomBits = $random(seed);
			outReady = randomBits[0];
			@(posedge clk);
			#2;
			done = outReady;
			count++;
			if (count > WAIT_LIMIT)
				abortRun($sformatf("Output of test %s was never taken", testName[op]));
		end
		outReady = 1'b0;
	endtask

	initial
	begin
		seed = 32'h82a9_3745;
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadRow = '0;
		vectorCount = 0;
		readTestData();
		if (vectorCount == 0)
			abortRun("No test vectors found in layerEngine_testdata.txt");
		repeat (4) @(posedge clk);
		#2;
		// Neither stream is open while reset is high
		checkValue("reset", "inReady", 0, int'(inReady));
		checkValue("reset", "outValid", 0, int'(outValid));
		reset = 1'b0;
		for (int op = 0; op < isVector.size(); op++)
		begin
			if (isVector[op])
				runVector(op);
			else
				loadWeights(op);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: layerEngine_testdata.txt
# W index w0 .. w14 bias
# V name a0 .. a14, then the 16 expected outputs of neurons 0 .. 15
W 0 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 0
W 1 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 100
W 2 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 -1 500
W 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 3 -1000
W 4 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 -30000
W 5 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 0
W 6 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 0
W 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4000
W 8 64 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
W 9 0 0 32 0 0 0 0 0 0 0 0 0 0 0 0 4096
W 10 0 0 0 0 -64 0 0 0 0 0 0 0 0 0 0 1000
W 11 0 0 0 0 0 0 16 0 0 0 0 0 0 0 0 -16
W 12 0 0 0 0 0 0 0 0 100 0 0 0 0 0 0 -50
W 13 0 0 0 0 0 0 0 0 0 0 -7 0 0 0 0 7
W 14 0 0 0 0 0 0 0 0 0 0 0 0 50 0 0 20
W 15 0 0 0 0 0 0 0 0 0 0 0 0 0 0 127 -2000
V ramp 1 3 5 7 9 11 13 15 17 19 21 23 25 27 29
  4 9 4 0 0 127 0 63 1 67 7 3 26 0 20 26
V flat 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
  2 6 5 0 0 127 0 63 10 69 6 2 15 0 8 0
V negative -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20
  0 0 13 0 0 0 127 63 0 54 36 0 0 2 0 0
V maxPos 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127
  30 61 0 74 0 127 0 63 127 127 0 32 127 0 100 127
V minNeg -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128 -128
  0 0 38 0 0 0 127 63 0 0 127 0 0 14 0 0
V mixed 5 -7 9 -11 13 -15 17 -19 21 -23 25 -27 29 -31 33
  0 2 8 0 0 38 0 63 5 69 3 4 32 0 23 34
# Reload of four rows while idle
W 0 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 -2 2000
W 4 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 30000
W 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -1
W 15 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -128 100
V ramp2 1 3 5 7 9 11 13 15 17 19 21 23 25 27 29
  24 9 4 0 127 127 0 0 1 67 7 3 26 0 20 0
V flat2 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
  27 6 5 0 127 127 0 0 10 69 6 2 15 0 8 0
V negative2 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20 -20
  41 0 13 0 127 0 127 0 0 54 36 0 0 2 0 42

// File: project.f
nnPkg.sv
neuronDot.sv
weightStore.sv
neuronCounter.sv
layerControl.sv
resultBuffer.sv
layerEngine.sv
layerEngine_asserts.sv
tb_layerEngine.sv

// File: Makefile
SIM = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_layerEngine
FILELIST = project.f
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, pass or fail from $(LOG)"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
